/* include/calc_macros.svh */
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// Operand, result and register file word width
`define CALC_WIDTH 16

// Nibble cycles per ALU operation
`define CALC_STAGES 4

// Register file words
// 0 operand one
// 1 operand two
// 2 last result
// 3 completed calculations
`define CALC_DEPTH 4

`endif

/* source/calc_pkg.sv */
`include "calc_macros.svh"

package calc_pkg;

    // Keypad entry FSM states
    typedef enum logic [2:0] {
        FIRST_NUM  = 3'd0,                  // Collecting operand one
        SECOND_NUM = 3'd1,                  // Collecting operand two
        SEND       = 3'd2,                  // Start pulse to the ALU
        WAIT_ALU   = 3'd3,                  // Waiting for finish
        SHOW       = 3'd4                   // Result on display
    } calc_state_e;

    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } calc_op_e;

    // Register file word map
    typedef enum logic [$clog2(`CALC_DEPTH)-1:0] {
        ADDR_OPND1  = 0,
        ADDR_OPND2  = 1,
        ADDR_RESULT = 2,
        ADDR_COUNT  = 3
    } calc_addr_e;

endpackage

/* source/calc_alu_if.sv */
`timescale 1ns/10ps
`include "calc_macros.svh"

interface calc_alu_if;

    logic [`CALC_WIDTH-1:0] a;              // Operand one
    logic [`CALC_WIDTH-1:0] b;              // Operand two
    calc_pkg::calc_op_e     op;
    logic                   start;          // One-cycle request pulse
    logic [`CALC_WIDTH-1:0] result;         // Valid with finish
    logic                   finish;         // One-cycle done pulse

    // Keypad side issues the request
    modport decode (
        output a,
        output b,
        output op,
        output start,
        input  finish
    );

    modport execute (
        input  a,
        input  b,
        input  op,
        input  start,
        output result,
        output finish
    );

    // Result side only watches completion
    modport store (
        input  result,
        input  finish
    );

endinterface

/* source/key_decode.sv */
`timescale 1ns/10ps
`include "calc_macros.svh"

module key_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   key_valid,
    input  logic [3:0]             key_digit,
    input  logic                   op_valid,
    input  calc_pkg::calc_op_e     op_sel,
    input  logic                   equal,
    output logic                   busy,
    output logic                   opnd_we,
    output calc_pkg::calc_addr_e   opnd_addr,
    output logic [`CALC_WIDTH-1:0] opnd_data,
    calc_alu_if.decode             alu
);

    localparam int W = `CALC_WIDTH;

    calc_pkg::calc_state_e state_q;
    calc_pkg::calc_state_e state_d;
    calc_pkg::calc_op_e    op_q;            // Latched operator

    logic [W-1:0] operand1;
    logic [W-1:0] operand2;
    logic [W-1:0] acc_src;                  // Operand being built
    logic [W-1:0] acc_next;                 // Operand with new digit appended
    logic         entry;
    logic         digit_ok;

    assign entry    = (state_q == calc_pkg::FIRST_NUM) || (state_q == calc_pkg::SECOND_NUM);
    assign digit_ok = entry && key_valid && (key_digit <= 4'd9);   // Codes above 9 dropped
    assign busy     = state_q inside {calc_pkg::SEND, calc_pkg::WAIT_ALU, calc_pkg::SHOW};

    // Decimal shift that wraps modulo 2^W
    assign acc_src  = (state_q == calc_pkg::FIRST_NUM) ? operand1 : operand2;
    assign acc_next = W'(acc_src * W'(10)) + W'(key_digit);

    // Operands stay put from SEND until the FSM leaves SHOW
    assign alu.a     = operand1;
    assign alu.b     = operand2;
    assign alu.op    = op_q;
    assign alu.start = (state_q == calc_pkg::SEND);

    // A digit takes priority over operator or equal in the same cycle
    always_comb begin
        state_d = state_q;
        case (state_q)
            calc_pkg::FIRST_NUM: begin
                if (!digit_ok && op_valid)
                    state_d = calc_pkg::SECOND_NUM;
            end
            calc_pkg::SECOND_NUM: begin
                if (!digit_ok && equal)
                    state_d = calc_pkg::SEND;
            end
            calc_pkg::SEND: begin
                state_d = calc_pkg::WAIT_ALU;
            end
            calc_pkg::WAIT_ALU: begin
                if (alu.finish)
                    state_d = calc_pkg::SHOW;
            end
            calc_pkg::SHOW: begin
                state_d = calc_pkg::FIRST_NUM;
            end
            default: begin
                state_d = calc_pkg::FIRST_NUM;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q  <= calc_pkg::FIRST_NUM;
            op_q     <= calc_pkg::OP_ADD;
            operand1 <= '0;
            operand2 <= '0;
            opnd_we  <= 1'b0;
        end else begin
            state_q <= state_d;
            opnd_we <= digit_ok;                        // Copy to register file next edge
            if (digit_ok) begin
                if (state_q == calc_pkg::FIRST_NUM)
                    operand1 <= acc_next;
                else
                    operand2 <= acc_next;
            end
            if ((state_q == calc_pkg::FIRST_NUM) && op_valid && !digit_ok)
                op_q <= op_sel;
            if (state_q == calc_pkg::SHOW) begin        // Fresh entry for next calculation
                operand1 <= '0;
                operand2 <= '0;
            end
        end
    end

    // Write request payload for the register file
    always_ff @(posedge clk) begin
        if (digit_ok) begin
            if (state_q == calc_pkg::FIRST_NUM)
                opnd_addr <= calc_pkg::ADDR_OPND1;
            else
                opnd_addr <= calc_pkg::ADDR_OPND2;
            opnd_data <= acc_next;
        end
    end

endmodule

/* source/alu_execute.sv */
`timescale 1ns/10ps
`include "calc_macros.svh"

module alu_execute (
    input  logic        clk,
    input  logic        reset,
    calc_alu_if.execute alu
);

    localparam int W      = `CALC_WIDTH;
    localparam int STAGES = `CALC_STAGES;
    localparam int NIB    = W / STAGES;                     // Bits handled per cycle
    localparam int SW     = (STAGES > 1) ? $clog2(STAGES) : 1;

    logic               running;
    logic [SW-1:0]      stage;
    logic               carry;              // Carry or inverted borrow between nibbles
    logic               finish_q;
    calc_pkg::calc_op_e op_q;
    logic [W-1:0]       a_sh;
    logic [W-1:0]       b_sh;
    logic [W-1:0]       res_sh;             // Result nibbles enter from the top
    logic               step;
    logic               load;
    logic               sub_now;
    logic               cin;
    logic [NIB-1:0]     nib_a;
    logic [NIB-1:0]     nib_b;
    logic [NIB:0]       nib_sum;

    // First nibble comes straight off the bus in the start cycle
    assign load    = alu.start && !running;
    assign step    = running || alu.start;
    assign sub_now = running ? (op_q == calc_pkg::OP_SUB) : (alu.op == calc_pkg::OP_SUB);
    assign nib_a   = running ? a_sh[NIB-1:0] : alu.a[NIB-1:0];
    assign nib_b   = (running ? b_sh[NIB-1:0] : alu.b[NIB-1:0]) ^ {NIB{sub_now}};
    assign cin     = running ? carry : sub_now;     // Subtract is a + ~b + 1
    assign nib_sum = {1'b0, nib_a} + {1'b0, nib_b} + {{NIB{1'b0}}, cin};

    assign alu.result = res_sh;
    assign alu.finish = finish_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running  <= 1'b0;
            stage    <= '0;
            carry    <= 1'b0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (step) begin
                carry <= nib_sum[NIB];
                if (stage == SW'(STAGES - 1)) begin     // Last nibble done
                    running  <= 1'b0;
                    stage    <= '0;
                    finish_q <= 1'b1;
                end else begin
                    running <= 1'b1;
                    stage   <= stage + SW'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            a_sh <= alu.a >> NIB;
            b_sh <= alu.b >> NIB;
            op_q <= alu.op;
        end else if (running) begin
            a_sh <= a_sh >> NIB;
            b_sh <= b_sh >> NIB;
        end
        if (step)
            res_sh <= {nib_sum[NIB-1:0], res_sh[W-1:NIB]};
    end

endmodule

/* source/result_store.sv */
`timescale 1ns/10ps
`include "calc_macros.svh"

module result_store (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   opnd_we,
    input  calc_pkg::calc_addr_e   opnd_addr,
    input  logic [`CALC_WIDTH-1:0] opnd_data,
    calc_alu_if.store              alu,
    input  calc_pkg::calc_addr_e   mem_addr,
    input  logic                   oe,
    output logic [`CALC_WIDTH-1:0] data,
    output logic [`CALC_WIDTH-1:0] display_output,
    output logic                   complete
);

    localparam int W     = `CALC_WIDTH;
    localparam int DEPTH = `CALC_DEPTH;

    logic [W-1:0] regs [DEPTH];
    logic [W-1:0] count_next;

    assign count_next = regs[calc_pkg::ADDR_COUNT] + W'(1);    // Wraps at 2^W

    // Operand copies from decode and the result and counter from the ALU
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (opnd_we)
                regs[opnd_addr] <= opnd_data;
            if (alu.finish) begin
                regs[calc_pkg::ADDR_RESULT] <= alu.result;
                regs[calc_pkg::ADDR_COUNT]  <= count_next;
            end
        end
    end

    // Display holds the last result until the next finish
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            display_output <= '0;
            complete       <= 1'b0;
        end else begin
            complete <= alu.finish;                 // One cycle after finish
            if (alu.finish)
                display_output <= alu.result;
        end
    end

    // Registered read port with one cycle latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data <= '0;
        end else if (oe) begin
            data <= regs[mem_addr];
        end
    end

endmodule

/* source/calc_top.sv */
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   key_valid,
    input  logic [3:0]             key_digit,
    input  logic                   op_valid,
    input  logic                   op_sel,          // 0 add, 1 subtract
    input  logic                   equal,
    input  logic [1:0]             mem_addr,
    input  logic                   oe,
    output logic                   busy,
    output logic                   complete,
    output logic [`CALC_WIDTH-1:0] display_output,
    output logic [`CALC_WIDTH-1:0] data
);

    logic                   opnd_we;
    calc_pkg::calc_addr_e   opnd_addr;
    logic [`CALC_WIDTH-1:0] opnd_data;

    calc_alu_if alu_bus ();                         // Decode to ALU to result store

    key_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .key_valid (key_valid),
        .key_digit (key_digit),
        .op_valid  (op_valid),
        .op_sel    (calc_pkg::calc_op_e'(op_sel)),
        .equal     (equal),
        .busy      (busy),
        .opnd_we   (opnd_we),
        .opnd_addr (opnd_addr),
        .opnd_data (opnd_data),
        .alu       (alu_bus.decode)
    );

    alu_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .alu   (alu_bus.execute)
    );

    result_store u_result (
        .clk            (clk),
        .reset          (reset),
        .opnd_we        (opnd_we),
        .opnd_addr      (opnd_addr),
        .opnd_data      (opnd_data),
        .alu            (alu_bus.store),
        .mem_addr       (calc_pkg::calc_addr_e'(mem_addr)),
        .oe             (oe),
        .data           (data),
        .display_output (display_output),
        .complete       (complete)
    );

endmodule

/* testbench/calc_tb.sv */
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_tb;

    localparam int W     = `CALC_WIDTH;
    localparam int LIMIT = 40;                  // Cycle budget for each wait loop

    logic         clk = 1'b0;
    logic         reset;
    logic         key_valid;
    logic [3:0]   key_digit;
    logic         op_valid;
    logic         op_sel;
    logic         equal;
    logic [1:0]   mem_addr;
    logic         oe;
    logic         busy;
    logic         complete;
    logic [W-1:0] display_output;
    logic [W-1:0] data;

    int           errors;                       // Failures in the running test
    int           passed;
    int           failed;
    int           done_count;                   // Calculations completed so far
    logic         pick_sub;
    logic [W-1:0] a_model;
    logic [W-1:0] b_model;
    logic [W-1:0] r_model;

    calc_top u_calc_top (.*);

    always #10 clk = ~clk;

    // Completion is one cycle long and lands while decode is in SHOW
    assert property (@(posedge clk) disable iff (reset) complete |-> busy ##1 !complete)
    else begin
        $display("complete pulse was longer than one cycle or came outside SHOW");
        errors++;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;                                     // Drive point after the edge
    endtask

    task automatic expect_value(input string name, input logic [W-1:0] expected,
                                input logic [W-1:0] actual);
        assert (actual === expected)
        else begin
            $display("Fail %s expected 0x%h got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic report_test(input string name);
        if (errors == 0) begin
            passed++;
            $display("Test %s passed", name);
        end else begin
            failed++;
            $display("Test %s failed with %0d errors", name, errors);
        end
        errors = 0;
    endtask

    // Idle inputs, or every key at once while the DUT is busy
    task automatic drive_keys(input bit junk);
        key_valid = junk;
        key_digit = 4'($urandom % 16);
        op_valid  = junk;
        op_sel    = 1'($urandom % 2);
        equal     = junk;
    endtask

    task automatic press_digit(input logic [3:0] d, inout logic [W-1:0] model);
        key_valid = 1'b1;
        key_digit = d;
        next_cycle();
        key_valid = 1'b0;
        if (d <= 4'd9)
            model = model * W'(10) + W'(d);     // Decimal append that wraps at 2^16
    endtask

    task automatic press_op(input logic sub);
        op_valid = 1'b1;
        op_sel   = sub;
        next_cycle();
        op_valid = 1'b0;
    endtask

    task automatic press_equal();
        equal = 1'b1;
        next_cycle();
        equal = 1'b0;
    endtask

    // Keys in a fixed decimal number, or 1 to 6 random digits
    task automatic enter_operand(input bit fixed, input int unsigned num,
                                 inout logic [W-1:0] model);
        int digits[$];
        if (fixed) begin
            do begin
                digits.push_front(int'(num % 10));
                num = num / 10;
            end while (num != 0);
        end else begin
            repeat (1 + $urandom % 6)
                digits.push_back(int'($urandom % 10));
        end
        foreach (digits[i])
            press_digit(4'(digits[i]), model);
    endtask

    task automatic read_check(input logic [1:0] addr, input logic [W-1:0] expected);
        mem_addr = addr;
        oe       = 1'b1;
        next_cycle();
        oe       = 1'b0;
        expect_value($sformatf("data[%0d]", addr), expected, data);
    endtask

    // Equal, then complete five cycles later, then back to idle
    task automatic run_equal(input bit junk);
        int cycles;
        cycles = 0;
        press_equal();
        while (!complete) begin
            if (cycles == LIMIT)
                abort_run("complete");
            drive_keys(junk && busy);
            next_cycle();
            cycles++;
        end
        expect_value("complete latency", W'(5), W'(cycles));
        expect_value("display_output", r_model, display_output);
        done_count++;
        cycles = 0;
        while (busy) begin
            if (cycles == LIMIT)
                abort_run("busy to drop");
            drive_keys(junk && busy);
            next_cycle();
            cycles++;
        end
        drive_keys(1'b0);
    endtask

    task automatic calculate(input logic sub, input bit fixed, input int unsigned fa,
                             input int unsigned fb);
        a_model = '0;
        b_model = '0;
        enter_operand(fixed, fa, a_model);
        press_op(sub);
        enter_operand(fixed, fb, b_model);
        r_model = sub ? a_model - b_model : a_model + b_model;
        run_equal(1'b0);
    endtask

    initial begin
        void'($urandom(32'h36b0));
        reset      = 1'b1;
        key_valid  = 1'b0;
        key_digit  = 4'd0;
        op_valid   = 1'b0;
        op_sel     = 1'b0;
        equal      = 1'b0;
        mem_addr   = 2'd0;
        oe         = 1'b0;
        errors     = 0;
        passed     = 0;
        failed     = 0;
        done_count = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        expect_value("busy", '0, W'(busy));
        expect_value("complete", '0, W'(complete));
        expect_value("display_output", '0, display_output);
        expect_value("data", '0, data);
        for (int i = 0; i < 4; i++)
            read_check(2'(i), '0);
        report_test("reset values");

        calculate(1'b0, 1'b1, 60000, 9999);     // Sum past 2^16
        calculate(1'b0, 1'b1, 123456, 7);       // Operand wraps during entry
        repeat (3) calculate(1'b0, 1'b0, 0, 0);
        report_test("addition");

        calculate(1'b1, 1'b1, 12, 345);         // Smaller minus larger
        calculate(1'b1, 1'b1, 500, 499);
        repeat (3) calculate(1'b1, 1'b0, 0, 0);
        report_test("subtraction");

        read_check(2'd0, a_model);
        read_check(2'd1, b_model);
        read_check(2'd2, r_model);
        read_check(2'd3, W'(done_count));
        report_test("register readback");

        a_model = '0;
        b_model = '0;
        press_equal();                          // Still FIRST_NUM
        expect_value("busy", '0, W'(busy));
        for (int c = 10; c < 16; c++)
            press_digit(4'(c), a_model);
        enter_operand(1'b0, 0, a_model);
        press_op(1'b1);
        press_op(1'b0);                         // Must not turn subtract into add
        press_digit(4'd11, b_model);
        enter_operand(1'b0, 0, b_model);
        r_model = a_model - b_model;
        run_equal(1'b1);
        repeat (8) begin
            next_cycle();
            expect_value("complete", '0, W'(complete));
        end
        read_check(2'd0, a_model);
        read_check(2'd1, b_model);
        read_check(2'd3, W'(done_count));
        report_test("ignored inputs");

        for (int n = 0; n < 4; n++) begin
            pick_sub = 1'($urandom % 2);
            a_model  = '0;
            b_model  = '0;
            enter_operand(1'b0, 0, a_model);
            next_cycle();                       // Register file copy lags one edge
            read_check(2'd0, a_model);
            press_op(pick_sub);
            enter_operand(1'b0, 0, b_model);
            r_model = pick_sub ? a_model - b_model : a_model + b_model;
            run_equal(1'b0);
        end
        read_check(2'd3, W'(done_count));
        report_test("back-to-back");

        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
source/calc_pkg.sv
source/calc_alu_if.sv
source/key_decode.sv
source/alu_execute.sv
source/result_store.sv
source/calc_top.sv
testbench/calc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= calc_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)

check: run
	@if grep -q '^=== PASS ===$$' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
